// ==== verilog/lb_bridge_pkg.sv ====
package lb_bridge_pkg;

   // -------------------------------------------------------------------------
   // Stream and command types
   // -------------------------------------------------------------------------

   // One received byte per gmii_rx_clk cycle
   typedef struct packed {
      logic [7:0] data;
      // Frame valid
      logic       dv;
      // Line error, bad code group inside a frame
      logic       er;
   } gmii_byte_t;

   // Record opcode byte
   typedef enum logic [7:0] {
      LB_WRITE = 8'h01,
      LB_READ  = 8'h02
   } lb_op_e;

   // One decoded 8-byte record, opcode in the top byte
   typedef struct packed {
      lb_op_e      op;
      logic [23:0] addr;
      logic [31:0] wdata;
   } lb_cmd_t;

   // -------------------------------------------------------------------------
   // FSM states
   // -------------------------------------------------------------------------

   // PCS receive side
   typedef enum logic {
      IDLE,
      IN_FRAME
   } pcs_state_e;

   // Frame parser
   typedef enum logic [2:0] {
      PREAMBLE,
      DEST_MAC,
      SRC_MAC,
      ETHERTYPE,
      RECORDS,
      DISCARD
   } parse_state_e;

   // -------------------------------------------------------------------------
   // Constants
   // -------------------------------------------------------------------------

   // Station address, first byte on the wire is the top byte
   localparam logic [47:0] LOCAL_MAC     = 48'h112233445566;
   localparam logic [15:0] CMD_ETHERTYPE = 16'h88B5;

   // Queue depth, also the parser's starting credit
   localparam int CMD_FIFO_DEPTH = 4;
   localparam int CREDIT_W       = 3;

   // Code groups as abcdei_fghj with a in bit 9, RD- form
   // RD+ form is the bitwise complement for all three
   localparam logic [9:0] K28_5 = 10'b001111_1010;
   localparam logic [9:0] K27_7 = 10'b110110_1000;
   localparam logic [9:0] K29_7 = 10'b101110_1000;

endpackage

// ==== verilog/pcs_rx_decode.sv ====
module pcs_rx_decode (
   input  logic                      gmii_rx_clk,
   input  logic                      arst_n,
   input  logic [19:0]               gtx_rxd,
   input  logic                      gtx_word_stb,
   output lb_bridge_pkg::gmii_byte_t rx_byte
);
   import lb_bridge_pkg::*;

   // -------------------------------------------------------------------------
   // 8b/10b lookup tables
   // -------------------------------------------------------------------------

   // abcdei to EDCBA, bit 5 set when the sub-block is a legal data code
   function automatic logic [5:0] dec_6b(input logic [5:0] s);
      logic [5:0] r;
      case (s)
         6'b100111, 6'b011000: r = {1'b1, 5'd0};
         6'b011101, 6'b100010: r = {1'b1, 5'd1};
         6'b101101, 6'b010010: r = {1'b1, 5'd2};
         6'b110001:            r = {1'b1, 5'd3};
         6'b110101, 6'b001010: r = {1'b1, 5'd4};
         6'b101001:            r = {1'b1, 5'd5};
         6'b011001:            r = {1'b1, 5'd6};
         6'b111000, 6'b000111: r = {1'b1, 5'd7};
         6'b111001, 6'b000110: r = {1'b1, 5'd8};
         6'b100101:            r = {1'b1, 5'd9};
         6'b010101:            r = {1'b1, 5'd10};
         6'b110100:            r = {1'b1, 5'd11};
         6'b001101:            r = {1'b1, 5'd12};
         6'b101100:            r = {1'b1, 5'd13};
         6'b011100:            r = {1'b1, 5'd14};
         6'b010111, 6'b101000: r = {1'b1, 5'd15};
         6'b011011, 6'b100100: r = {1'b1, 5'd16};
         6'b100011:            r = {1'b1, 5'd17};
         6'b010011:            r = {1'b1, 5'd18};
         6'b110010:            r = {1'b1, 5'd19};
         6'b001011:            r = {1'b1, 5'd20};
         6'b101010:            r = {1'b1, 5'd21};
         6'b011010:            r = {1'b1, 5'd22};
         6'b111010, 6'b000101: r = {1'b1, 5'd23};
         6'b110011, 6'b001100: r = {1'b1, 5'd24};
         6'b100110:            r = {1'b1, 5'd25};
         6'b010110:            r = {1'b1, 5'd26};
         6'b110110, 6'b001001: r = {1'b1, 5'd27};
         6'b001110:            r = {1'b1, 5'd28};
         6'b101110, 6'b010001: r = {1'b1, 5'd29};
         6'b011110, 6'b100001: r = {1'b1, 5'd30};
         6'b101011, 6'b010100: r = {1'b1, 5'd31};
         default:              r = 6'd0;
      endcase
      return r;
   endfunction

   // fghj to HGF, bit 3 set when legal
   function automatic logic [3:0] dec_4b(input logic [3:0] s);
      logic [3:0] r;
      case (s)
         4'b1011, 4'b0100: r = {1'b1, 3'd0};
         4'b1001:          r = {1'b1, 3'd1};
         4'b0101:          r = {1'b1, 3'd2};
         4'b1100, 4'b0011: r = {1'b1, 3'd3};
         4'b1101, 4'b0010: r = {1'b1, 3'd4};
         4'b1010:          r = {1'b1, 3'd5};
         4'b0110:          r = {1'b1, 3'd6};
         // Primary and alternate D.x.7
         4'b1110, 4'b0001,
         4'b0111, 4'b1000: r = {1'b1, 3'd7};
         default:          r = 4'd0;
      endcase
      return r;
   endfunction

   // -------------------------------------------------------------------------
   // Symbol selection
   // -------------------------------------------------------------------------

   pcs_state_e state;
   logic [9:0] sym_q;
   logic [5:0] d6;
   logic [3:0] d4;
   logic       code_ok;
   logic [7:0] code_byte;
   logic       is_start;
   logic       is_end;
   logic       is_idle;

   // Low half on the strobe cycle, high half on the one after
   // Comma out of reset so the FSM never sees X
   always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
      if (!arst_n) begin
         sym_q <= K28_5;
      end else begin
         sym_q <= gtx_word_stb ? gtx_rxd[9:0] : gtx_rxd[19:10];
      end
   end

   // Special codes, either disparity
   assign is_start = (sym_q == K27_7) || (sym_q == ~K27_7);
   assign is_end   = (sym_q == K29_7) || (sym_q == ~K29_7);
   assign is_idle  = (sym_q == K28_5) || (sym_q == ~K28_5);

   assign d6        = dec_6b(sym_q[9:4]);
   assign d4        = dec_4b(sym_q[3:0]);
   assign code_ok   = d6[5] & d4[3];
   assign code_byte = {d4[2:0], d6[4:0]};

   // -------------------------------------------------------------------------
   // Frame delimiting
   // -------------------------------------------------------------------------

   always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
      if (!arst_n) begin
         state   <= IDLE;
         rx_byte <= '0;
      end else begin
         // Default is an empty cycle
         rx_byte <= '0;
         case (state)
            IDLE: begin
               // /S/ stands in for the first preamble byte
               if (is_start) begin
                  state        <= IN_FRAME;
                  rx_byte.data <= 8'h55;
                  rx_byte.dv   <= 1'b1;
               end
            end
            IN_FRAME: begin
               if (is_end || is_idle) begin
                  state <= IDLE;
               end else begin
                  rx_byte.dv <= 1'b1;
                  // Stray /S/ or a bad group flags the byte
                  if (is_start || !code_ok) begin
                     rx_byte.er <= 1'b1;
                  end else begin
                     rx_byte.data <= code_byte;
                  end
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

endmodule

// ==== verilog/frame_cmd_parser.sv ====
module frame_cmd_parser (
   input  logic                      gmii_rx_clk,
   input  logic                      arst_n,
   input  lb_bridge_pkg::gmii_byte_t rx_byte,
   output lb_bridge_pkg::lb_cmd_t    cmd,
   output logic                      cmd_push,
   input  logic                      credit_return,
   output logic [15:0]               drop_count
);
   import lb_bridge_pkg::*;

   parse_state_e        state;
   // Byte index within the current field or record
   logic [2:0]          byte_cnt;
   // First seven bytes of the record in flight
   logic [55:0]         rec_q;
   logic [CREDIT_W-1:0] credit;
   logic                mac_byte_ok;
   logic                type_byte_ok;
   logic                op_ok;
   logic                rec_done;
   logic                push_now;

   // -------------------------------------------------------------------------
   // Field compares
   // -------------------------------------------------------------------------

   // Destination MAC goes out top byte first
   assign mac_byte_ok  = rx_byte.data == LOCAL_MAC[47 - 8*byte_cnt -: 8];
   assign type_byte_ok = rx_byte.data ==
                         (byte_cnt[0] ? CMD_ETHERTYPE[7:0] : CMD_ETHERTYPE[15:8]);
   assign op_ok        = (rx_byte.data == LB_WRITE) || (rx_byte.data == LB_READ);

   // Eighth record byte, clean
   assign rec_done = (state == RECORDS) && rx_byte.dv && !rx_byte.er &&
                     (byte_cnt == 3'd7);
   assign push_now = rec_done && (credit != '0);

   // -------------------------------------------------------------------------
   // Parse FSM
   // -------------------------------------------------------------------------

   always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= PREAMBLE;
         byte_cnt <= '0;
      end else if (!rx_byte.dv) begin
         // End of frame, partial record is lost
         state    <= PREAMBLE;
         byte_cnt <= '0;
      end else if (rx_byte.er) begin
         state <= DISCARD;
      end else begin
         case (state)
            PREAMBLE: begin
               if (rx_byte.data == 8'hD5) begin
                  state    <= DEST_MAC;
                  byte_cnt <= '0;
               end else if (rx_byte.data != 8'h55) begin
                  state <= DISCARD;
               end
            end
            DEST_MAC: begin
               if (!mac_byte_ok) begin
                  state <= DISCARD;
               end else if (byte_cnt == 3'd5) begin
                  state    <= SRC_MAC;
                  byte_cnt <= '0;
               end else begin
                  byte_cnt <= byte_cnt + 1'b1;
               end
            end
            SRC_MAC: begin
               // Any sender accepted
               if (byte_cnt == 3'd5) begin
                  state    <= ETHERTYPE;
                  byte_cnt <= '0;
               end else begin
                  byte_cnt <= byte_cnt + 1'b1;
               end
            end
            ETHERTYPE: begin
               if (!type_byte_ok) begin
                  state <= DISCARD;
               end else if (byte_cnt == 3'd1) begin
                  state    <= RECORDS;
                  byte_cnt <= '0;
               end else begin
                  byte_cnt <= byte_cnt + 1'b1;
               end
            end
            RECORDS: begin
               // Opcode check on the first byte, counter wraps every 8 bytes
               if (byte_cnt == 3'd0 && !op_ok) begin
                  state <= DISCARD;
               end else begin
                  byte_cnt <= byte_cnt + 1'b1;
               end
            end
            DISCARD: ;
            default: state <= DISCARD;
         endcase
      end
   end

   // -------------------------------------------------------------------------
   // Record assembly
   // -------------------------------------------------------------------------

   always_ff @(posedge gmii_rx_clk) begin
      if (state == RECORDS && rx_byte.dv) begin
         rec_q <= {rec_q[47:0], rx_byte.data};
      end
      if (push_now) begin
         cmd <= lb_cmd_t'({rec_q, rx_byte.data});
      end
   end

   // Credits and drop counter
   always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
      if (!arst_n) begin
         credit     <= CREDIT_W'(CMD_FIFO_DEPTH);
         cmd_push   <= 1'b0;
         drop_count <= '0;
      end else begin
         cmd_push <= push_now;
         // Push and return together cancel out
         case ({push_now, credit_return})
            2'b10:   credit <= credit - 1'b1;
            2'b01:   credit <= credit + 1'b1;
            default: ;
         endcase
         // Saturates at all ones
         if (rec_done && credit == '0 && drop_count != '1) begin
            drop_count <= drop_count + 1'b1;
         end
      end
   end

endmodule

// ==== verilog/lb_cmd_issue.sv ====
module lb_cmd_issue (
   input  logic                   gmii_rx_clk,
   input  logic                   arst_n,
   input  lb_bridge_pkg::lb_cmd_t cmd,
   input  logic                   cmd_push,
   output logic                   credit_return,
   input  logic                   lb_busy,
   output logic                   lb_valid,
   output logic                   lb_rnw,
   output logic [23:0]            lb_addr,
   output logic [31:0]            lb_wdata,
   output logic                   lb_renable,
   input  logic [31:0]            lb_rdata,
   output logic                   rd_valid,
   output logic [31:0]            rd_data
);
   import lb_bridge_pkg::*;

   // -------------------------------------------------------------------------
   // Command queue
   // -------------------------------------------------------------------------

   lb_cmd_t                             queue [CMD_FIFO_DEPTH];
   // Depth is a power of two so the pointers wrap on their own
   logic [$clog2(CMD_FIFO_DEPTH)-1:0]   wr_ptr;
   logic [$clog2(CMD_FIFO_DEPTH)-1:0]   rd_ptr;
   logic [CREDIT_W-1:0]                 fill;
   lb_cmd_t                             head;
   logic                                pop;

   assign head = queue[rd_ptr];
   // One issue per cycle, held off by the bus
   assign pop  = (fill != '0) && !lb_busy;

   // Credit scheme keeps this from overrunning
   always_ff @(posedge gmii_rx_clk) begin
      if (cmd_push) begin
         queue[wr_ptr] <= cmd;
      end
   end

   always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (cmd_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({cmd_push, pop})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: ;
         endcase
      end
   end

   // -------------------------------------------------------------------------
   // Bus sequencing
   // -------------------------------------------------------------------------

   always_ff @(posedge gmii_rx_clk or negedge arst_n) begin
      if (!arst_n) begin
         lb_valid      <= 1'b0;
         lb_rnw        <= 1'b0;
         credit_return <= 1'b0;
         lb_renable    <= 1'b0;
         rd_valid      <= 1'b0;
      end else begin
         lb_valid      <= pop;
         // One credit back per record taken off the queue
         credit_return <= pop;
         if (pop) begin
            lb_rnw <= (head.op == LB_READ);
         end
         // Read tag stage 1, bus sample cycle
         lb_renable <= lb_valid && lb_rnw;
         // Stage 2, result out
         rd_valid   <= lb_renable;
      end
   end

   // Address, write data and read result
   always_ff @(posedge gmii_rx_clk) begin
      if (pop) begin
         lb_addr  <= head.addr;
         lb_wdata <= head.wdata;
      end
      if (lb_renable) begin
         rd_data <= lb_rdata;
      end
   end

endmodule

// ==== verilog/gtx_lb_bridge_top.sv ====
module gtx_lb_bridge_top (
   input  logic        gmii_rx_clk,
   input  logic        arst_n,
   input  logic [19:0] gtx_rxd,
   input  logic        gtx_word_stb,
   output logic        lb_valid,
   output logic        lb_rnw,
   output logic [23:0] lb_addr,
   output logic [31:0] lb_wdata,
   output logic        lb_renable,
   input  logic [31:0] lb_rdata,
   input  logic        lb_busy,
   output logic        rd_valid,
   output logic [31:0] rd_data,
   output logic [15:0] drop_count
);
   import lb_bridge_pkg::*;

   // PCS to parser byte stream
   gmii_byte_t rx_byte;
   // Parser to issue, credit based
   lb_cmd_t    cmd;
   logic       cmd_push;
   logic       credit_return;

   // -------------------------------------------------------------------------
   // Receive chain
   // -------------------------------------------------------------------------

   pcs_rx_decode pcs_i (
      .gmii_rx_clk  (gmii_rx_clk),
      .arst_n       (arst_n),
      .gtx_rxd      (gtx_rxd),
      .gtx_word_stb (gtx_word_stb),
      .rx_byte      (rx_byte)
   );

   frame_cmd_parser parser_i (
      .gmii_rx_clk   (gmii_rx_clk),
      .arst_n        (arst_n),
      .rx_byte       (rx_byte),
      .cmd           (cmd),
      .cmd_push      (cmd_push),
      .credit_return (credit_return),
      .drop_count    (drop_count)
   );

   lb_cmd_issue issue_i (
      .gmii_rx_clk   (gmii_rx_clk),
      .arst_n        (arst_n),
      .cmd           (cmd),
      .cmd_push      (cmd_push),
      .credit_return (credit_return),
      .lb_busy       (lb_busy),
      .lb_valid      (lb_valid),
      .lb_rnw        (lb_rnw),
      .lb_addr       (lb_addr),
      .lb_wdata      (lb_wdata),
      .lb_renable    (lb_renable),
      .lb_rdata      (lb_rdata),
      .rd_valid      (rd_valid),
      .rd_data       (rd_data)
   );

endmodule

// ==== verif/gtx_lb_bridge_chk.sv ====
module gtx_lb_bridge_chk (
   input logic                               gmii_rx_clk,
   input logic                               arst_n,
   input logic                               lb_busy,
   input logic                               lb_valid,
   input logic                               lb_rnw,
   input logic                               rd_valid,
   input logic [lb_bridge_pkg::CREDIT_W-1:0] credit,
   input logic [lb_bridge_pkg::CREDIT_W-1:0] fill
);
   timeunit 1ns;
   timeprecision 100ps;
   import lb_bridge_pkg::*;

   // Busy bus and nothing queued, no issue next cycle
   busy_empty_no_issue: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
      (lb_busy && fill == '0) |=> !lb_valid)
      else $error("lb_valid after busy cycle with empty queue");

   // Read result two cycles after the read issue
   read_result_follows: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
      ($past(lb_valid, 2) && $past(lb_rnw, 2)) |-> rd_valid)
      else $error("rd_valid missing two cycles after read");

   // Credits never above queue depth
   credit_bounded: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
      credit <= CREDIT_W'(CMD_FIFO_DEPTH))
      else $error("parser credit count above queue depth");

   lb_valid_known: assert property (@(posedge gmii_rx_clk) disable iff (!arst_n)
      !$isunknown(lb_valid))
      else $error("lb_valid unknown");

endmodule

bind gtx_lb_bridge_top gtx_lb_bridge_chk chk_i (
   .gmii_rx_clk (gmii_rx_clk),
   .arst_n      (arst_n),
   .lb_busy     (lb_busy),
   .lb_valid    (lb_valid),
   .lb_rnw      (lb_rnw),
   .rd_valid    (rd_valid),
   .credit      (parser_i.credit),
   .fill        (issue_i.fill)
);

// ==== verif/gtx_lb_bridge_tb.sv ====
module gtx_lb_bridge_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import lb_bridge_pkg::*;

   // Any sender address is accepted
   localparam logic [47:0] PEER_MAC   = 48'h02005e102030;
   // Illegal in both 6b and 4b sub-blocks
   localparam logic [9:0]  BAD_GROUP  = 10'b000000_0000;
   localparam int          WAIT_LIMIT = 600;
   // RD- column of the 5b/6b and 3b/4b codes as abcdei and fghj
   localparam logic [5:0] ENC6 [32] = '{
      6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
      6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
      6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
      6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011};
   localparam logic [3:0] ENC4 [8] = '{
      4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110};

   logic        gmii_rx_clk = 1'b0;
   logic        arst_n;
   logic [19:0] gtx_rxd;
   logic        gtx_word_stb;
   logic [31:0] lb_rdata = '0;
   logic        lb_busy;
   logic        lb_valid;
   logic        lb_rnw;
   logic [23:0] lb_addr;
   logic [31:0] lb_wdata;
   logic        lb_renable;
   logic        rd_valid;
   logic [31:0] rd_data;
   logic [15:0] drop_count;

   int          seed = 32'hd679_37ed;
   int          errors = 0;
   int          checks = 0;
   // Record bytes of the next frame
   logic [7:0]  payload [$];
   // Commands as {rnw, addr, wdata}
   logic [56:0] exp_cmd [$];
   logic [56:0] obs_cmd [$];
   logic [31:0] exp_rd [$];
   logic [31:0] obs_rd [$];
   // Read issued on the bus in the previous cycle
   logic        read_issued_q = 1'b0;

   gtx_lb_bridge_top dut_i (.*);

   always #4 gmii_rx_clk = ~gmii_rx_clk;

   // -------------------------------------------------------------------------
   // Bus monitor and memory model
   // -------------------------------------------------------------------------

   function automatic logic [31:0] mem_word(input logic [23:0] a);
      return {a[7:0], ~a};
   endfunction

   always @(posedge gmii_rx_clk) begin
      if (arst_n && lb_valid) begin
         obs_cmd.push_back({lb_rnw, lb_addr, lb_wdata});
      end
      if (arst_n && rd_valid) begin
         obs_rd.push_back(rd_data);
      end
      // Sample strobe exactly one cycle after each read issue
      if (arst_n) begin
         check_value("lb_renable", lb_renable, read_issued_q);
      end
      read_issued_q <= arst_n && lb_valid && lb_rnw;
      // Read data valid through the lb_renable cycle
      if (lb_valid && lb_rnw) begin
         lb_rdata <= mem_word(lb_addr);
      end
   end

   // -------------------------------------------------------------------------
   // Stimulus helpers
   // -------------------------------------------------------------------------

   function automatic logic [9:0] enc_8b10b(input logic [7:0] b);
      return {ENC6[b[4:0]], ENC4[b[7:5]]};
   endfunction

   // Random record as op byte then address and data MSB first
   task automatic add_record(input logic [7:0] op, input logic issued);
      logic [31:0] r;
      logic [23:0] addr;
      logic [31:0] data;
      int          i;
      r    = $random(seed);
      addr = r[23:0];
      data = $random(seed);
      payload.push_back(op);
      for (i = 2; i >= 0; i--) payload.push_back(addr[8*i +: 8]);
      for (i = 3; i >= 0; i--) payload.push_back(data[8*i +: 8]);
      if (issued) begin
         exp_cmd.push_back({op == LB_READ, addr, data});
         if (op == LB_READ) begin
            exp_rd.push_back(mem_word(addr));
         end
      end
   endtask

   // Bad group replaces payload byte bad_at unless it is -1
   task automatic send_frame(input logic [47:0] dst, input logic [15:0] etype, input int bad_at);
      logic [9:0] syms [$];
      int         i;
      syms.push_back(K27_7);
      for (i = 0; i < 7; i++) syms.push_back(enc_8b10b(8'h55));
      syms.push_back(enc_8b10b(8'hD5));
      for (i = 0; i < 6; i++) syms.push_back(enc_8b10b(dst[47-8*i -: 8]));
      for (i = 0; i < 6; i++) syms.push_back(enc_8b10b(PEER_MAC[47-8*i -: 8]));
      syms.push_back(enc_8b10b(etype[15:8]));
      syms.push_back(enc_8b10b(etype[7:0]));
      for (i = 0; i < payload.size(); i++) begin
         syms.push_back((i == bad_at) ? BAD_GROUP : enc_8b10b(payload[i]));
      end
      syms.push_back(K29_7);
      syms.push_back(K28_5);
      // Pad to whole words
      if (syms.size() % 2 != 0) begin
         syms.push_back(K28_5);
      end
      // Two symbols per word with the low half first and the strobe on its first cycle
      for (i = 0; i < syms.size(); i += 2) begin
         @(posedge gmii_rx_clk);
         gtx_rxd      <= {syms[i+1], syms[i]};
         gtx_word_stb <= 1'b1;
         @(posedge gmii_rx_clk);
         gtx_word_stb <= 1'b0;
      end
      @(posedge gmii_rx_clk);
      gtx_rxd <= {K28_5, K28_5};
      payload = {};
   endtask

   // -------------------------------------------------------------------------
   // Waits and checks
   // -------------------------------------------------------------------------

   // Counts bus commands (0), read results (1) or drops (2)
   function automatic int progress(input int what);
      case (what)
         0:       return obs_cmd.size();
         1:       return obs_rd.size();
         default: return int'(drop_count);
      endcase
   endfunction

   task automatic wait_for(input int what, input int target, input string label);
      int cyc;
      cyc = 0;
      while (progress(what) < target && cyc < WAIT_LIMIT) begin
         @(negedge gmii_rx_clk);
         cyc++;
      end
      if (progress(what) < target) begin
         errors++;
         $display("Timed out after %0d cycles waiting for %0d %s", cyc, target, label);
      end
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) @(negedge gmii_rx_clk);
   endtask

   task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERR %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // Observed against expected in order before clearing both
   task automatic compare_results(input string name);
      int i;
      check_value({name, " command count"}, obs_cmd.size(), exp_cmd.size());
      for (i = 0; i < exp_cmd.size() && i < obs_cmd.size(); i++) begin
         check_value({name, " command"}, obs_cmd[i], exp_cmd[i]);
      end
      check_value({name, " read count"}, obs_rd.size(), exp_rd.size());
      for (i = 0; i < exp_rd.size() && i < obs_rd.size(); i++) begin
         check_value({name, " read data"}, obs_rd[i], exp_rd[i]);
      end
      obs_cmd = {};
      exp_cmd = {};
      obs_rd  = {};
      exp_rd  = {};
   endtask

   // -------------------------------------------------------------------------
   // Tests
   // -------------------------------------------------------------------------

   task automatic issue_writes();
      repeat (3) add_record(LB_WRITE, 1'b1);
      send_frame(LOCAL_MAC, CMD_ETHERTYPE, -1);
      wait_for(0, 3, "write commands");
      idle_cycles(30);
      compare_results("writes");
   endtask

   task automatic return_reads();
      repeat (2) add_record(LB_READ, 1'b1);
      send_frame(LOCAL_MAC, CMD_ETHERTYPE, -1);
      wait_for(1, 2, "read results");
      idle_cycles(30);
      compare_results("reads");
   endtask

   task automatic filter_frames();
      repeat (2) add_record(LB_WRITE, 1'b0);
      send_frame(LOCAL_MAC ^ 48'h1, CMD_ETHERTYPE, -1);
      repeat (2) add_record(LB_WRITE, 1'b0);
      send_frame(LOCAL_MAC, 16'h0800, -1);
      // Undefined opcode discards the rest of the frame
      add_record(LB_WRITE, 1'b1);
      add_record(8'h07, 1'b0);
      add_record(LB_WRITE, 1'b0);
      send_frame(LOCAL_MAC, CMD_ETHERTYPE, -1);
      wait_for(0, 1, "filtered commands");
      idle_cycles(30);
      compare_results("filtering");
   endtask

   task automatic hold_off_bus();
      int base;
      base = int'(drop_count);
      @(posedge gmii_rx_clk);
      lb_busy <= 1'b1;
      // Only four credits so records five and six are lost
      repeat (4) add_record(LB_WRITE, 1'b1);
      repeat (2) add_record(LB_WRITE, 1'b0);
      send_frame(LOCAL_MAC, CMD_ETHERTYPE, -1);
      wait_for(2, base + 2, "dropped records");
      @(posedge gmii_rx_clk);
      lb_busy <= 1'b0;
      wait_for(0, 4, "queued commands");
      idle_cycles(30);
      compare_results("backpressure");
      check_value("drop count", drop_count, base + 2);
   endtask

   task automatic cut_bad_frames();
      repeat (2) add_record(LB_WRITE, 1'b1);
      add_record(LB_WRITE, 1'b0);
      // Fourth byte of the third record
      send_frame(LOCAL_MAC, CMD_ETHERTYPE, 19);
      wait_for(0, 2, "commands before line error");
      idle_cycles(30);
      compare_results("line error");
      // Frame cut after five bytes of the third record
      repeat (2) add_record(LB_WRITE, 1'b1);
      add_record(LB_WRITE, 1'b0);
      repeat (3) void'(payload.pop_back());
      send_frame(LOCAL_MAC, CMD_ETHERTYPE, -1);
      wait_for(0, 2, "commands before truncation");
      idle_cycles(30);
      compare_results("truncation");
   endtask

   initial begin
      arst_n       = 1'b0;
      gtx_rxd      = {K28_5, K28_5};
      gtx_word_stb = 1'b0;
      lb_busy      = 1'b0;
      repeat (4) @(posedge gmii_rx_clk);
      arst_n <= 1'b1;
      repeat (4) @(posedge gmii_rx_clk);
      issue_writes();
      return_reads();
      filter_frames();
      hold_off_bus();
      cut_bad_frames();
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   --top-module gtx_lb_bridge_tb \
   -f filelist.f

./obj_dir/Vgtx_lb_bridge_tb 2>&1 | tee sim.log

if grep -q "Some tests failed" sim.log; then
   echo "Simulation FAILED"
   exit 1
fi
echo "Simulation PASSED"

// ==== filelist.f ====
verilog/lb_bridge_pkg.sv
verilog/pcs_rx_decode.sv
verilog/frame_cmd_parser.sv
verilog/lb_cmd_issue.sv
verilog/gtx_lb_bridge_top.sv
verif/gtx_lb_bridge_chk.sv
verif/gtx_lb_bridge_tb.sv
